// ==== Bender.yml ====
package:
  name: pio_tx_engine

sources:
  - include_dirs:
      - include
    files:
      - hw/pio_pkg.sv
      - hw/cpl_req_if.sv
      - hw/bar_cpl_source.sv
      - hw/cc_arbiter.sv
      - hw/cc_packer.sv
      - hw/pio_tx_engine.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_pio_tx_engine.sv

// ==== hw/bar_cpl_source.sv ====
module bar_cpl_source import pio_pkg::*; (
    input  logic        pcie_clk,
    input  logic        pcie_rst,

    input  logic [2:0]  req_tc,
    input  logic [1:0]  req_attr,
    input  logic [15:0] req_rid,
    input  logic [7:0]  req_tag,
    input  logic [3:0]  req_be,     // First-dword byte enables
    input  logic [15:0] req_addr,
    input  logic [1:0]  req_at,

    input  logic        rd_valid,
    input  logic [31:0] rd_data,
    output logic        rd_ready,

    cpl_req_if.source   cpl
);

    logic          valid_q;
    pio_cpl_desc_t desc_q;
    logic [11:0]   byte_cnt;
    logic [1:0]    first_be_idx;
    logic          rd_take;

    // Span from lowest to highest enabled byte, inclusive
    function automatic logic [11:0] be_byte_count(input logic [3:0] be);
        logic [2:0] lo;
        logic [2:0] hi;
        logic       found;
        lo    = 3'd0;
        hi    = 3'd0;
        found = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                if (!found) begin
                    lo = 3'(i);    // First set bit seen
                end
                hi    = 3'(i);
                found = 1'b1;
            end
        end
        if (!found) begin
            return 12'd1;          // Zero-length read reports one byte
        end
        return 12'(hi - lo + 3'd1);
    endfunction

    assign byte_cnt = be_byte_count(req_be);

    // Index of the lowest enabled byte within the dword
    always_comb begin
        casez (req_be)
            4'b???1: first_be_idx = 2'd0;
            4'b??10: first_be_idx = 2'd1;
            4'b?100: first_be_idx = 2'd2;
            4'b1000: first_be_idx = 2'd3;
            default: first_be_idx = 2'd0;   // No enables
        endcase
    end

    // One descriptor at a time
    assign rd_ready = !valid_q;
    assign rd_take  = rd_valid && rd_ready;

    always_ff @(posedge pcie_clk) begin
        if (pcie_rst) begin
            valid_q <= 1'b0;
            desc_q  <= '0;
        end else begin
            if (rd_take) begin
                valid_q             <= 1'b1;
                desc_q.data         <= rd_data;
                desc_q.tc           <= req_tc;
                desc_q.attr         <= req_attr;
                desc_q.rid          <= req_rid;
                desc_q.tag          <= req_tag;
                desc_q.at           <= req_at;
                desc_q.byte_cnt     <= byte_cnt;
                desc_q.lower_addr   <= {req_addr[6:2], first_be_idx};
            end else if (cpl.valid && cpl.ready) begin
                valid_q <= 1'b0;    // Arbiter took it
            end
        end
    end

    assign cpl.valid = valid_q;
    assign cpl.desc  = desc_q;

endmodule

// ==== hw/cc_arbiter.sv ====
module cc_arbiter import pio_pkg::*; (
    input  logic      pcie_clk,
    input  logic      pcie_rst,

    cpl_req_if.sink   req0,     // BAR0, highest priority
    cpl_req_if.sink   req1,     // BAR1
    cpl_req_if.source grant
);

    logic          stage_valid;
    pio_cpl_desc_t stage_desc;
    logic          stage_free;
    logic          gnt0;
    logic          gnt1;

    // Stage can load when empty or when the packer takes it this cycle
    assign stage_free = !stage_valid || grant.ready;

    // Fixed priority, BAR0 first
    assign gnt0 = req0.valid;
    assign gnt1 = !req0.valid && req1.valid;

    assign req0.ready = gnt0 && stage_free;
    assign req1.ready = gnt1 && stage_free;

    always_ff @(posedge pcie_clk) begin
        if (pcie_rst) begin
            stage_valid <= 1'b0;
            stage_desc  <= '0;
        end else begin
            if (req0.valid && req0.ready) begin
                stage_valid <= 1'b1;
                stage_desc  <= req0.desc;
            end else if (req1.valid && req1.ready) begin
                stage_valid <= 1'b1;
                stage_desc  <= req1.desc;
            end else if (grant.ready) begin
                stage_valid <= 1'b0;   // Drained with nothing behind it
            end
        end
    end

    assign grant.valid = stage_valid;
    assign grant.desc  = stage_desc;

endmodule

// ==== hw/cc_packer.sv ====
`include "pio_cfg.svh"

module cc_packer import pio_pkg::*; (
    input  logic                       pcie_clk,
    input  logic                       pcie_rst,

    cpl_req_if.sink                    cpl,

    output logic [`PIO_DATA_WIDTH-1:0] tdata,
    output logic                       tvalid,
    input  logic                       tready
);

    cc_state_e state;
    logic      cpl_take;

    // Completion-with-data descriptor plus payload, one beat
    function automatic logic [`PIO_DATA_WIDTH-1:0] pack_cpl(input pio_cpl_desc_t d);
        return {
            d.data,                   // 127:96
            1'b0,                     // Force ECRC
            1'b0, d.attr,             // Attributes
            d.tc,
            1'b0,                     // Completer ID enable
            `PIO_CPL_BUS,
            `PIO_CPL_DEVFN,
            d.tag,
            d.rid,
            1'b0,                     // Reserved
            1'b0,                     // Poisoned
            CPL_STATUS_SC,            // PIO reads always succeed
            `PIO_CPL_DW_COUNT,
            2'b00,                    // Reserved
            1'b0,                     // Locked read
            {1'b0, d.byte_cnt},       // 13-bit byte count
            6'b0,                     // Reserved
            d.at,
            1'b0,                     // Reserved
            d.lower_addr              // 6:0
        };
    endfunction

    // Take a new descriptor when idle or when the current beat leaves
    assign cpl.ready = (state == CC_IDLE) || tready;
    assign cpl_take  = cpl.valid && cpl.ready;

    always_ff @(posedge pcie_clk) begin
        if (pcie_rst) begin
            state <= CC_IDLE;
            tdata <= '0;
        end else begin
            case (state)
                CC_IDLE: begin
                    if (cpl_take) begin
                        tdata <= pack_cpl(cpl.desc);
                        state <= CC_SEND;
                    end
                end
                CC_SEND: begin
                    if (cpl_take) begin
                        tdata <= pack_cpl(cpl.desc);   // Back-to-back beat
                    end else if (tready) begin
                        state <= CC_IDLE;
                    end
                end
                default: state <= CC_IDLE;
            endcase
        end
    end

    // tdata holds until tready since it only reloads on a transfer
    assign tvalid = (state == CC_SEND);

endmodule

// ==== hw/cpl_req_if.sv ====
interface cpl_req_if import pio_pkg::*; ();

    logic          valid;   // Descriptor offered
    logic          ready;   // Sink can take it
    pio_cpl_desc_t desc;    // Stable while valid is high

    // Producer side
    modport source (
        output valid,
        output desc,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid,
        input  desc,
        output ready
    );

endinterface

// ==== hw/pio_pkg.sv ====
package pio_pkg;

    // Fields needed to build one completion-with-data header
    typedef struct packed {
        logic [31:0] data;        // Read result from the BAR
        logic [2:0]  tc;          // Traffic class of the request
        logic [1:0]  attr;        // Relaxed ordering / no snoop
        logic [15:0] rid;         // Requester ID
        logic [7:0]  tag;         // Request tag
        logic [1:0]  at;          // Address translation
        logic [11:0] byte_cnt;    // Bytes remaining
        logic [6:0]  lower_addr;  // Address of first enabled byte
    } pio_cpl_desc_t;

    // Completion status codes from the PCIe spec
    typedef enum logic [2:0] {
        CPL_STATUS_SC = 3'b000,   // Successful completion
        CPL_STATUS_UR = 3'b001,   // Unsupported request
        CPL_STATUS_CA = 3'b100    // Completer abort
    } cpl_status_e;

    // Packer states
    typedef enum logic {
        CC_IDLE = 1'b0,
        CC_SEND = 1'b1
    } cc_state_e;

endpackage

// ==== hw/pio_tx_engine.sv ====
`include "pio_cfg.svh"

module pio_tx_engine (
    input  logic                       pcie_clk,
    input  logic                       pcie_rst,

    // BAR0 read result and request fields
    input  logic [2:0]                 bar0_req_tc,
    input  logic [1:0]                 bar0_req_attr,
    input  logic [15:0]                bar0_req_rid,
    input  logic [7:0]                 bar0_req_tag,
    input  logic [3:0]                 bar0_req_be,
    input  logic [15:0]                bar0_req_addr,
    input  logic [1:0]                 bar0_req_at,
    input  logic                       bar0_rd_valid,
    input  logic [31:0]                bar0_rd_data,
    output logic                       bar0_rd_ready,

    // BAR1 read result and request fields
    input  logic [2:0]                 bar1_req_tc,
    input  logic [1:0]                 bar1_req_attr,
    input  logic [15:0]                bar1_req_rid,
    input  logic [7:0]                 bar1_req_tag,
    input  logic [3:0]                 bar1_req_be,
    input  logic [15:0]                bar1_req_addr,
    input  logic [1:0]                 bar1_req_at,
    input  logic                       bar1_rd_valid,
    input  logic [31:0]                bar1_rd_data,
    output logic                       bar1_rd_ready,

    // Completer completion stream
    output logic [`PIO_DATA_WIDTH-1:0] s_axis_cc_tdata,
    output logic                       s_axis_cc_tvalid,
    input  logic                       s_axis_cc_tready
);

    cpl_req_if bar0_cpl ();   // BAR0 source to arbiter
    cpl_req_if bar1_cpl ();   // BAR1 source to arbiter
    cpl_req_if arb_cpl ();    // Arbiter to packer

    bar_cpl_source bar0_src_i (
        .pcie_clk (pcie_clk),
        .pcie_rst (pcie_rst),
        .req_tc   (bar0_req_tc),
        .req_attr (bar0_req_attr),
        .req_rid  (bar0_req_rid),
        .req_tag  (bar0_req_tag),
        .req_be   (bar0_req_be),
        .req_addr (bar0_req_addr),
        .req_at   (bar0_req_at),
        .rd_valid (bar0_rd_valid),
        .rd_data  (bar0_rd_data),
        .rd_ready (bar0_rd_ready),
        .cpl      (bar0_cpl.source)
    );

    bar_cpl_source bar1_src_i (
        .pcie_clk (pcie_clk),
        .pcie_rst (pcie_rst),
        .req_tc   (bar1_req_tc),
        .req_attr (bar1_req_attr),
        .req_rid  (bar1_req_rid),
        .req_tag  (bar1_req_tag),
        .req_be   (bar1_req_be),
        .req_addr (bar1_req_addr),
        .req_at   (bar1_req_at),
        .rd_valid (bar1_rd_valid),
        .rd_data  (bar1_rd_data),
        .rd_ready (bar1_rd_ready),
        .cpl      (bar1_cpl.source)
    );

    cc_arbiter arb_i (
        .pcie_clk (pcie_clk),
        .pcie_rst (pcie_rst),
        .req0     (bar0_cpl.sink),
        .req1     (bar1_cpl.sink),
        .grant    (arb_cpl.source)
    );

    cc_packer pack_i (
        .pcie_clk (pcie_clk),
        .pcie_rst (pcie_rst),
        .cpl      (arb_cpl.sink),
        .tdata    (s_axis_cc_tdata),
        .tvalid   (s_axis_cc_tvalid),
        .tready   (s_axis_cc_tready)
    );

endmodule

// ==== include/pio_cfg.svh ====
`ifndef PIO_CFG_SVH
`define PIO_CFG_SVH

// Completion beat on the CC AXI-stream
`define PIO_DATA_WIDTH    128

// Completer ID placed in every completion header
`define PIO_CPL_BUS       8'hAA
`define PIO_CPL_DEVFN     8'hF8   // Device 31, function 0

// PIO reads always return a single dword
`define PIO_CPL_DW_COUNT  11'd1

`endif

// ==== list.f ====
+incdir+include
hw/pio_pkg.sv
hw/cpl_req_if.sv
hw/bar_cpl_source.sv
hw/cc_arbiter.sv
hw/cc_packer.sv
hw/pio_tx_engine.sv
sim/tb_pio_tx_engine.sv

// ==== sim/tb_pio_tx_engine.sv ====
`include "pio_cfg.svh"

module tb_pio_tx_engine import pio_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACCEPT_TIMEOUT = 200;   // Cycles a read may wait for ready
    localparam int BEAT_TIMEOUT   = 50;
    localparam int DRAIN_TIMEOUT  = 1000;

    logic                       pcie_clk;
    logic                       pcie_rst;
    logic [2:0]                 bar0_req_tc, bar1_req_tc;
    logic [1:0]                 bar0_req_attr, bar1_req_attr;
    logic [15:0]                bar0_req_rid, bar1_req_rid;
    logic [7:0]                 bar0_req_tag, bar1_req_tag;
    logic [3:0]                 bar0_req_be, bar1_req_be;
    logic [15:0]                bar0_req_addr, bar1_req_addr;
    logic [1:0]                 bar0_req_at, bar1_req_at;
    logic                       bar0_rd_valid, bar1_rd_valid;
    logic [31:0]                bar0_rd_data, bar1_rd_data;
    logic                       bar0_rd_ready, bar1_rd_ready;
    logic [`PIO_DATA_WIDTH-1:0] s_axis_cc_tdata;
    logic                       s_axis_cc_tvalid;
    logic                       s_axis_cc_tready;

    integer       seed = 32'h5215_a8e6;
    logic [127:0] q0[$];          // Expected beats per BAR, in accept order
    logic [127:0] q1[$];
    int           emitted[$];     // BAR index of each beat that left
    int           cycle;
    int           acc_cycle0;
    int           acc_cycle1;
    logic         held_valid;
    logic [127:0] held_data;
    logic         stall_seen;
    int           bp_mode;        // 0 ready, 1 long stalls, 2 random per cycle
    int           bp_left;
    logic [6:0]   tag0;
    logic [6:0]   tag1;

    pio_tx_engine dut_i (.*);

    initial begin
        pcie_clk = 1'b0;
        forever #2 pcie_clk = ~pcie_clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Completion beat built field by field from the header layout
    function automatic logic [127:0] expected_beat(
        input logic [2:0] tc, input logic [1:0] attr, input logic [15:0] rid,
        input logic [7:0] tag, input logic [3:0] be, input logic [15:0] addr,
        input logic [1:0] at, input logic [31:0] data);
        logic [127:0] beat;
        int           lo;
        int           hi;
        logic [12:0]  bc;
        logic [6:0]   la;
        lo = 4;
        hi = -1;
        for (int i = 3; i >= 0; i--) begin
            if (be[i]) lo = i;     // Ends on the lowest set bit
        end
        for (int i = 0; i < 4; i++) begin
            if (be[i]) hi = i;
        end
        if (hi < 0) begin
            bc = 13'd1;
            la = {addr[6:2], 2'b00};
        end else begin
            bc = 13'(hi - lo + 1);
            la = {addr[6:2], 2'(lo)};
        end
        beat            = '0;
        beat[6:0]       = la;
        beat[9:8]       = at;
        beat[28:16]     = bc;
        beat[42:32]     = `PIO_CPL_DW_COUNT;
        beat[45:43]     = 3'd0;    // Successful completion
        beat[63:48]     = rid;
        beat[71:64]     = tag;
        beat[79:72]     = `PIO_CPL_DEVFN;
        beat[87:80]     = `PIO_CPL_BUS;
        beat[91:89]     = tc;
        beat[93:92]     = attr;
        beat[127:96]    = data;
        return beat;
    endfunction

    // Accept monitor and output scoreboard
    always @(posedge pcie_clk) begin
        logic [127:0] exp_beat;
        int           bar;
        int           inflight;
        cycle++;
        if (!pcie_rst) begin
            inflight = q0.size() + q1.size();   // Both sources, stage and packer hold one
            if (inflight == 4) begin
                check_value("bar0_rd_ready", bar0_rd_ready, 1'b0);
                check_value("bar1_rd_ready", bar1_rd_ready, 1'b0);
                stall_seen = 1'b1;
            end
            if (bar0_rd_valid && bar0_rd_ready) begin
                q0.push_back(expected_beat(bar0_req_tc, bar0_req_attr, bar0_req_rid,
                    bar0_req_tag, bar0_req_be, bar0_req_addr, bar0_req_at, bar0_rd_data));
                acc_cycle0 = cycle;
            end
            if (bar1_rd_valid && bar1_rd_ready) begin
                q1.push_back(expected_beat(bar1_req_tc, bar1_req_attr, bar1_req_rid,
                    bar1_req_tag, bar1_req_be, bar1_req_addr, bar1_req_at, bar1_rd_data));
                acc_cycle1 = cycle;
            end
            if (held_valid && !s_axis_cc_tvalid) begin
                abort_run("s_axis_cc_tvalid dropped before the beat was taken");
            end
            if (held_valid) begin
                check_value("s_axis_cc_tdata (held)", s_axis_cc_tdata, held_data);
            end
            if (s_axis_cc_tvalid && s_axis_cc_tready) begin
                bar = s_axis_cc_tdata[71];   // Tag MSB marks the BAR
                emitted.push_back(bar);
                if (bar == 0 && q0.size() == 0) begin
                    abort_run("A BAR0 completion left with no BAR0 read outstanding");
                end
                if (bar == 1 && q1.size() == 0) begin
                    abort_run("A BAR1 completion left with no BAR1 read outstanding");
                end
                exp_beat = (bar == 0) ? q0.pop_front() : q1.pop_front();
                check_value("s_axis_cc_tdata tag", s_axis_cc_tdata[71:64], exp_beat[71:64]);
                check_value("s_axis_cc_tdata", s_axis_cc_tdata, exp_beat);
                held_valid = 1'b0;
            end else begin
                held_valid = s_axis_cc_tvalid;
                held_data  = s_axis_cc_tdata;
            end
        end
    end

    // Consumer back-pressure
    always @(posedge pcie_clk) begin
        if (bp_mode == 1) begin
            if (bp_left == 0) begin
                s_axis_cc_tready <= !s_axis_cc_tready;
                bp_left = s_axis_cc_tready ? ($random(seed) & 15) : ($random(seed) & 3);
            end else begin
                bp_left--;
            end
        end else if (bp_mode == 2) begin
            s_axis_cc_tready <= (($random(seed) & 3) != 0);
        end else begin
            s_axis_cc_tready <= 1'b1;
        end
    end

    task automatic send_read(input int bar, input logic [3:0] be);
        int waited;
        @(posedge pcie_clk);
        if (bar == 0) begin
            bar0_req_tc   <= 3'($random(seed));
            bar0_req_attr <= 2'($random(seed));
            bar0_req_rid  <= 16'($random(seed));
            bar0_req_tag  <= {1'b0, tag0};
            bar0_req_be   <= be;
            bar0_req_addr <= 16'($random(seed));
            bar0_req_at   <= 2'($random(seed));
            bar0_rd_data  <= $random(seed);
            bar0_rd_valid <= 1'b1;
            tag0++;
        end else begin
            bar1_req_tc   <= 3'($random(seed));
            bar1_req_attr <= 2'($random(seed));
            bar1_req_rid  <= 16'($random(seed));
            bar1_req_tag  <= {1'b1, tag1};
            bar1_req_be   <= be;
            bar1_req_addr <= 16'($random(seed));
            bar1_req_at   <= 2'($random(seed));
            bar1_rd_data  <= $random(seed);
            bar1_rd_valid <= 1'b1;
            tag1++;
        end
        waited = 0;
        do begin
            @(posedge pcie_clk);
            waited++;
            if (waited > ACCEPT_TIMEOUT) begin
                abort_run($sformatf("BAR%0d read was never accepted", bar));
            end
        end while (!(bar == 0 ? (bar0_rd_valid && bar0_rd_ready)
                              : (bar1_rd_valid && bar1_rd_ready)));
        if (bar == 0) bar0_rd_valid <= 1'b0;
        else          bar1_rd_valid <= 1'b0;
    endtask

    task automatic run_bar_traffic(input int bar, input int count, input int max_gap);
        int gap;
        repeat (count) begin
            gap = $random(seed) & max_gap;
            repeat (gap) @(posedge pcie_clk);
            send_read(bar, 4'($random(seed)));
        end
    endtask

    // Edges from the accept edge until tvalid is seen
    task automatic wait_beat(output int cycles);
        cycles = 0;
        do begin
            @(posedge pcie_clk);
            cycles++;
            if (cycles > BEAT_TIMEOUT) abort_run("No completion beat appeared after a read");
        end while (!s_axis_cc_tvalid);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        do begin
            @(negedge pcie_clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) abort_run("Outstanding completions never drained");
        end while (q0.size() != 0 || q1.size() != 0 || s_axis_cc_tvalid);
    endtask

    initial begin
        int lat;
        pcie_rst = 1'b1;
        {bar0_req_tc, bar0_req_attr, bar0_req_rid, bar0_req_tag} = '0;
        {bar0_req_be, bar0_req_addr, bar0_req_at, bar0_rd_data} = '0;
        {bar1_req_tc, bar1_req_attr, bar1_req_rid, bar1_req_tag} = '0;
        {bar1_req_be, bar1_req_addr, bar1_req_at, bar1_rd_data} = '0;
        bar0_rd_valid    = 1'b0;
        bar1_rd_valid    = 1'b0;
        s_axis_cc_tready = 1'b1;
        {cycle, acc_cycle0, acc_cycle1, bp_mode, bp_left} = '0;
        {held_valid, held_data, stall_seen, tag0, tag1} = '0;
        repeat (5) @(posedge pcie_clk);
        pcie_rst <= 1'b0;

        @(posedge pcie_clk);   // Reset values
        check_value("s_axis_cc_tvalid", s_axis_cc_tvalid, 1'b0);
        check_value("bar0_rd_ready", bar0_rd_ready, 1'b1);
        check_value("bar1_rd_ready", bar1_rd_ready, 1'b1);

        send_read(0, 4'hF);    // Idle path latency
        wait_beat(lat);
        check_value("s_axis_cc_tvalid latency", lat, 3);
        wait_idle();

        for (int be = 0; be < 16; be++) begin
            send_read(0, 4'(be));
        end
        wait_idle();

        emitted.delete();      // Same-cycle requests, BAR0 wins
        fork
            send_read(0, 4'($random(seed)));
            send_read(1, 4'($random(seed)));
        join
        wait_idle();
        check_value("bar1 accept cycle", acc_cycle1, acc_cycle0);
        check_value("completion count", emitted.size(), 2);
        check_value("first completion BAR", emitted[0], 0);
        check_value("second completion BAR", emitted[1], 1);

        stall_seen = 1'b0;
        bp_mode    = 1;
        fork
            run_bar_traffic(0, 30, 0);
            run_bar_traffic(1, 30, 0);
        join
        wait_idle();
        if (!stall_seen) abort_run("The completion path never filled under back-pressure");

        bp_mode = 2;
        fork
            run_bar_traffic(0, 60, 3);
            run_bar_traffic(1, 60, 3);
        join
        wait_idle();

        bp_mode = 0;
        repeat (4) @(negedge pcie_clk);
        if (q0.size() == 0 && q1.size() == 0 && !s_axis_cc_tvalid) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("Completions were still outstanding at the end of the run");
        end
    end

endmodule
